//--- common/ctrl_cfg_pkg.sv
package ctrl_cfg_pkg;

    // ring size
    localparam int NUM_CTX = 4;
    localparam int CTX_W   = 2;

    // datapath widths
    localparam int ADDR_W  = 10;
    localparam int STEP_W  = 6;
    localparam int ITER_W  = 6;
    localparam int WIN_W   = 6;
    localparam int LANE_W  = 3;

    // step thresholds inside a pass
    localparam int LAST_STEP  = 63;
    localparam int MAC_LEAD   = 15;
    localparam int DRAIN_LAST = 7;

    // output buffer bases, one slot of eight lanes per context
    localparam logic [NUM_CTX-1:0][ADDR_W-1:0] OB_BASE = {
        ADDR_W'(24),
        ADDR_W'(16),
        ADDR_W'(8),
        ADDR_W'(0)
    };

    // weight buffer bases, one 64-entry window per context
    localparam logic [NUM_CTX-1:0][ADDR_W-1:0] WB_BASE = {
        ADDR_W'(192),
        ADDR_W'(128),
        ADDR_W'(64),
        ADDR_W'(0)
    };

endpackage

//--- common/ctrl_types_pkg.sv
package ctrl_types_pkg;

    import ctrl_cfg_pkg::*;

    typedef enum logic [2:0] {
        IDLE,
        START,
        CLEAR,
        MAC,
        UPDATE,
        DRAIN,
        DONE
    } seq_state_e;

    // one job context as it travels round the ring
    typedef struct packed {
        seq_state_e        state;
        logic [ITER_W-1:0] iter;
        logic [STEP_W-1:0] step;
        logic [ADDR_W-1:0] ib_addr;
        logic [ADDR_W-1:0] ob_addr;
        logic [ADDR_W-1:0] wb_w_addr;
        logic [ADDR_W-1:0] wb_r_addr;
        logic [ADDR_W-1:0] kb_r_addr;
        logic [CTX_W-1:0]  ib_sel;
        logic              ob_wr;
        logic              wb_wr;
        logic              wb_sel;
        logic              ex_sel;
        logic              update;
        logic              ml_clr;
        logic [LANE_W-1:0] ml_sel;
    } ctx_t;

endpackage

//--- common/ctx_if.sv
interface ctx_if (
    input logic clk_i
);

    import ctrl_cfg_pkg::*;
    import ctrl_types_pkg::*;

    ctx_t             head;
    ctx_t             next;
    ctx_t             issue0;
    ctx_t             issue1;
    logic [CTX_W-1:0] phase;
    logic             done_set;
    logic             done_clr;

    modport seq_mp (
        input  clk_i,
        input  head,
        input  phase,
        output next,
        output done_set,
        output done_clr
    );

    modport ring_mp (
        output head,
        output issue0,
        output issue1,
        output phase,
        input  next
    );

    modport issue_mp (
        input  issue0,
        input  issue1,
        input  phase,
        input  done_set,
        input  done_clr
    );

endinterface

//--- sequencer/ctx_sequencer.sv
module ctx_sequencer #(
    parameter int ADDR_W = 10
) (
    input  logic [ctrl_cfg_pkg::NUM_CTX-1:0]                         start_i,
    input  logic [ctrl_cfg_pkg::NUM_CTX-1:0][ctrl_cfg_pkg::ITER_W-1:0] iter_size_i,
    ctx_if.seq_mp                                                    ctx
);

    import ctrl_cfg_pkg::*;
    import ctrl_types_pkg::*;

    ctx_t head;
    ctx_t nxt;
    logic mac_issue;

    // low window advances, upper bits keep the context's bank
    function automatic logic [ADDR_W-1:0] win_inc(input logic [ADDR_W-1:0] a);
        return {a[ADDR_W-1:WIN_W], a[WIN_W-1:0] + WIN_W'(1)};
    endfunction

    function automatic logic [ADDR_W-1:0] win_fill(input logic [ADDR_W-1:0] a,
                                                   input logic fill);
        return {a[ADDR_W-1:WIN_W], {WIN_W{fill}}};
    endfunction

    assign head = ctx.head;

    // multiplier busy once the pipeline lead is filled, idle on the wrap step
    assign mac_issue = (head.step >= STEP_W'(MAC_LEAD)) && (head.step != STEP_W'(LAST_STEP));

    always_comb begin
        nxt        = head;
        nxt.step   = head.step + STEP_W'(1);
        nxt.ob_wr  = 1'b0;
        nxt.update = 1'b0;
        nxt.ml_clr = 1'b0;
        nxt.wb_wr  = 1'b1;

        case (head.state)
            IDLE: begin
                nxt.state     = start_i[ctx.phase] ? START : IDLE;
                nxt.iter      = iter_size_i[ctx.phase];
                nxt.step      = '0;
                nxt.ib_addr   = '0;
                nxt.ob_addr   = {head.ob_addr[ADDR_W-1:LANE_W], LANE_W'(0)};
                nxt.ib_sel    = ctx.phase;
                nxt.wb_w_addr = win_fill(head.wb_w_addr, 1'b0);
                nxt.wb_r_addr = win_fill(head.wb_r_addr, 1'b0);
                nxt.kb_r_addr = '0;
                nxt.wb_wr     = 1'b0;
                nxt.wb_sel    = 1'b0;
                nxt.ex_sel    = 1'b0;
                nxt.ml_sel    = '0;
            end
            START: begin
                // read pointers parked one behind so CLEAR lands on entry 0
                nxt.state     = CLEAR;
                nxt.step      = head.step;
                nxt.wb_w_addr = win_fill(head.wb_w_addr, 1'b0);
                nxt.wb_r_addr = win_fill(head.wb_r_addr, 1'b1);
                nxt.kb_r_addr = win_fill(head.kb_r_addr, 1'b1);
                nxt.ex_sel    = 1'b1;
                nxt.ml_clr    = 1'b1;
                nxt.ml_sel    = '0;
            end
            CLEAR: begin
                nxt.state     = MAC;
                nxt.ib_addr   = win_inc(head.ib_addr);
                nxt.wb_w_addr = win_inc(head.wb_w_addr);
                nxt.wb_r_addr = win_inc(head.wb_r_addr);
                nxt.kb_r_addr = win_inc(head.kb_r_addr);
                nxt.wb_sel    = 1'b0;
                nxt.ex_sel    = 1'b0;
                nxt.ml_clr    = 1'b1;
                nxt.ml_sel    = '0;
            end
            MAC: begin
                if (head.step == STEP_W'(LAST_STEP)) begin
                    nxt.state = (head.iter == '0) ? DRAIN : UPDATE;
                end else begin
                    nxt.state = MAC;
                end
                nxt.ib_addr   = mac_issue ? head.ib_addr : win_inc(head.ib_addr);
                nxt.wb_w_addr = win_inc(head.wb_w_addr);
                nxt.wb_r_addr = win_inc(head.wb_r_addr);
                nxt.kb_r_addr = win_inc(head.kb_r_addr);
                nxt.wb_sel    = mac_issue;
                nxt.ex_sel    = mac_issue;
                nxt.ml_sel    = '0;
            end
            UPDATE: begin
                nxt.state     = MAC;
                nxt.iter      = head.iter - ITER_W'(1);
                nxt.ib_addr   = win_inc(head.ib_addr);
                nxt.wb_w_addr = win_inc(head.wb_w_addr);
                nxt.wb_r_addr = win_inc(head.wb_r_addr);
                nxt.kb_r_addr = win_inc(head.kb_r_addr);
                nxt.wb_sel    = 1'b0;
                nxt.ex_sel    = 1'b0;
                nxt.update    = 1'b1;
                nxt.ml_sel    = '0;
            end
            DRAIN: begin
                // step wrapped to 0 on the last MAC, so it counts lanes here
                nxt.state   = (head.step == STEP_W'(DRAIN_LAST)) ? DONE : DRAIN;
                nxt.ob_wr   = 1'b1;
                nxt.ob_addr = {head.ob_addr[ADDR_W-1:LANE_W], head.step[LANE_W-1:0]};
                nxt.ml_sel  = head.step[LANE_W-1:0];
                nxt.ex_sel  = 1'b0;
            end
            DONE: begin
                nxt.state  = start_i[ctx.phase] ? DONE : IDLE;
                nxt.ex_sel = 1'b0;
            end
            default: begin
                nxt.state = IDLE;
            end
        endcase
    end

    assign ctx.next     = nxt;
    assign ctx.done_set = (head.state == DONE);
    assign ctx.done_clr = (head.state == IDLE);

    // the ring must only ever hand back records this FSM produced
    a_head_state_legal: assert property (
        @(posedge ctx.clk_i)
        head.state inside {IDLE, START, CLEAR, MAC, UPDATE, DRAIN, DONE}
    ) else $error("ring head carries illegal state %0d", head.state);

endmodule

//--- design/ctx_ring.sv
module ctx_ring #(
    parameter int ADDR_W = 10
) (
    input  logic   clk_i,
    input  logic   rst_ni,
    ctx_if.ring_mp ctx
);

    import ctrl_cfg_pkg::*;
    import ctrl_types_pkg::*;

    ctx_t             stage_q [NUM_CTX];
    logic [CTX_W-1:0] phase_q;

    // slot k starts out holding context k at its own buffer banks
    function automatic ctx_t slot_reset(input int unsigned k);
        ctx_t r;
        r           = '0;
        r.state     = IDLE;
        r.ob_addr   = ADDR_W'(OB_BASE[k]);
        r.wb_w_addr = ADDR_W'(WB_BASE[k]);
        r.wb_r_addr = ADDR_W'(WB_BASE[k]);
        return r;
    endfunction

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            phase_q <= CTX_W'(NUM_CTX - 1);
            for (int k = 0; k < NUM_CTX; k++) begin
                stage_q[k] <= slot_reset(k);
            end
        end else begin
            phase_q    <= phase_q - CTX_W'(1);
            stage_q[0] <= ctx.next;
            for (int k = 1; k < NUM_CTX; k++) begin
                stage_q[k] <= stage_q[k-1];
            end
        end
    end

    assign ctx.head   = stage_q[NUM_CTX-1];
    assign ctx.issue0 = stage_q[0];
    assign ctx.issue1 = stage_q[1];
    assign ctx.phase  = phase_q;

    // output writes only come out of a drain step one clock earlier
    a_ob_wr_drain_only: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        stage_q[0].ob_wr |-> $past(stage_q[NUM_CTX-1].state) == DRAIN
    ) else $error("ob_wr raised outside of DRAIN");

endmodule

//--- design/ctx_issue.sv
module ctx_issue #(
    parameter int ADDR_W = 10
) (
    input  logic                                clk_i,
    input  logic                                rst_ni,
    ctx_if.issue_mp                             ctx,
    output logic [ctrl_cfg_pkg::NUM_CTX-1:0]    done_o,
    output logic [ADDR_W-1:0]                   ob_addr_o,
    output logic [ADDR_W-1:0]                   ib_r_addr_o,
    output logic                                ob_wr_o,
    output logic [ctrl_cfg_pkg::CTX_W-1:0]      ib_r_sel_o,
    output logic [ADDR_W-1:0]                   wb_w_addr_o,
    output logic [ADDR_W-1:0]                   wb_r_addr_o,
    output logic                                wb_wr_o,
    output logic                                wb_sel_o,
    output logic [ADDR_W-1:0]                   kb_r_addr_o,
    output logic                                ex_sel_o,
    output logic [ctrl_cfg_pkg::LANE_W-1:0]     ml_sel_o,
    output logic                                update_o,
    output logic                                ml_clr_o
);

    import ctrl_cfg_pkg::*;
    import ctrl_types_pkg::*;

    logic [NUM_CTX-1:0] done_q;

    // read addresses go out a clock ahead to cover buffer read latency
    assign wb_r_addr_o = ctx.issue0.wb_r_addr;
    assign kb_r_addr_o = ctx.issue0.kb_r_addr;

    assign ob_addr_o   = ctx.issue1.ob_addr;
    assign ib_r_addr_o = ctx.issue1.ib_addr;
    assign ob_wr_o     = ctx.issue1.ob_wr;
    assign ib_r_sel_o  = ctx.issue1.ib_sel;
    assign wb_w_addr_o = ctx.issue1.wb_w_addr;
    assign wb_wr_o     = ctx.issue1.wb_wr;
    assign wb_sel_o    = ctx.issue1.wb_sel;
    assign ex_sel_o    = ctx.issue1.ex_sel;
    assign ml_sel_o    = ctx.issue1.ml_sel;
    assign update_o    = ctx.issue1.update;
    assign ml_clr_o    = ctx.issue1.ml_clr;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            done_q <= '0;
        end else if (ctx.done_set) begin
            done_q[ctx.phase] <= 1'b1;
        end else if (ctx.done_clr) begin
            done_q[ctx.phase] <= 1'b0;
        end
    end

    assign done_o = done_q;

    a_done_set_clr_excl: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        !(ctx.done_set && ctx.done_clr)
    ) else $error("done set and clear pulsed together");

endmodule

//--- design/mac_ctrl_top.sv
module mac_ctrl_top #(
    parameter int ADDR_W = ctrl_cfg_pkg::ADDR_W
) (
    input  logic                                                     clk_i,
    input  logic                                                     rst_ni,
    input  logic [ctrl_cfg_pkg::NUM_CTX-1:0]                         start_i,
    input  logic [ctrl_cfg_pkg::NUM_CTX-1:0][ctrl_cfg_pkg::ITER_W-1:0] iter_size_i,
    output logic [ctrl_cfg_pkg::NUM_CTX-1:0]                         done_o,
    output logic [ADDR_W-1:0]                                        ob_addr_o,
    output logic [ADDR_W-1:0]                                        ib_r_addr_o,
    output logic                                                     ob_wr_o,
    output logic [ctrl_cfg_pkg::CTX_W-1:0]                           ib_r_sel_o,
    output logic [ADDR_W-1:0]                                        wb_w_addr_o,
    output logic [ADDR_W-1:0]                                        wb_r_addr_o,
    output logic                                                     wb_wr_o,
    output logic                                                     wb_sel_o,
    output logic [ADDR_W-1:0]                                        kb_r_addr_o,
    output logic                                                     ex_sel_o,
    output logic [ctrl_cfg_pkg::LANE_W-1:0]                          ml_sel_o,
    output logic                                                     update_o,
    output logic                                                     ml_clr_o
);

    import ctrl_cfg_pkg::*;
    import ctrl_types_pkg::*;

    ctx_if u_ctx_if (
        .clk_i (clk_i)
    );

    ctx_sequencer #(
        .ADDR_W (ADDR_W)
    ) u_ctx_sequencer (
        .start_i     (start_i),
        .iter_size_i (iter_size_i),
        .ctx         (u_ctx_if.seq_mp)
    );

    ctx_ring #(
        .ADDR_W (ADDR_W)
    ) u_ctx_ring (
        .clk_i  (clk_i),
        .rst_ni (rst_ni),
        .ctx    (u_ctx_if.ring_mp)
    );

    ctx_issue #(
        .ADDR_W (ADDR_W)
    ) u_ctx_issue (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .ctx         (u_ctx_if.issue_mp),
        .done_o      (done_o),
        .ob_addr_o   (ob_addr_o),
        .ib_r_addr_o (ib_r_addr_o),
        .ob_wr_o     (ob_wr_o),
        .ib_r_sel_o  (ib_r_sel_o),
        .wb_w_addr_o (wb_w_addr_o),
        .wb_r_addr_o (wb_r_addr_o),
        .wb_wr_o     (wb_wr_o),
        .wb_sel_o    (wb_sel_o),
        .kb_r_addr_o (kb_r_addr_o),
        .ex_sel_o    (ex_sel_o),
        .ml_sel_o    (ml_sel_o),
        .update_o    (update_o),
        .ml_clr_o    (ml_clr_o)
    );

endmodule

//--- verif/tb_checks.svh
// compare tasks, one per kind of DUT result

task automatic check_addr(input string name, input logic [ADDR_W-1:0] got,
                          input logic [ADDR_W-1:0] exp);
    if (got !== exp) begin
        $display("Fail at %0t ns: %s got %0h expected %0h", $time, name, got, exp);
        abort_run();
    end
endtask

task automatic check_lane(input string name, input logic [LANE_W-1:0] got,
                          input logic [LANE_W-1:0] exp);
    if (got !== exp) begin
        $display("Fail at %0t ns: %s got %0d expected %0d", $time, name, got, exp);
        abort_run();
    end
endtask

task automatic check_done(input string name, input logic [NUM_CTX-1:0] got,
                          input logic [NUM_CTX-1:0] exp);
    if (got !== exp) begin
        $display("Fail at %0t ns: %s got %b expected %b", $time, name, got, exp);
        abort_run();
    end
endtask

task automatic check_count(input string name, input logic [ITER_W-1:0] got,
                           input logic [ITER_W-1:0] exp);
    if (got !== exp) begin
        $display("Fail at %0t ns: %s got %0d expected %0d", $time, name, got, exp);
        abort_run();
    end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        $display("Fail at %0t ns: %s got %b expected %b", $time, name, got, exp);
        abort_run();
    end
endtask

// polls done_o on falling edges until the masked bits match
task automatic wait_for_done(input logic [NUM_CTX-1:0] mask,
                             input logic [NUM_CTX-1:0] want, input int limit);
    int cycles;
    cycles = 0;
    do begin
        @(negedge clk_i);
        cycles++;
        if (cycles > limit) begin
            $display("timeout after %0d cycles waiting for done_o to reach %b under mask %b",
                     limit, want, mask);
            abort_run();
        end
    end while ((done_o & mask) !== want);
endtask

//--- verif/tb_mac_ctrl.sv
module tb_mac_ctrl;

    timeunit 1ns;
    timeprecision 1ps;

    import ctrl_cfg_pkg::*;
    import ctrl_types_pkg::*;

    localparam int STIM_COLS = 9;
    localparam int MAX_JOBS  = 16;

    logic                           clk_i;
    logic                           rst_ni;
    logic [NUM_CTX-1:0]             start_i;
    logic [NUM_CTX-1:0][ITER_W-1:0] iter_size_i;
    logic [NUM_CTX-1:0]             done_o;
    logic [ADDR_W-1:0]              ob_addr_o;
    logic [ADDR_W-1:0]              ib_r_addr_o;
    logic                           ob_wr_o;
    logic [CTX_W-1:0]               ib_r_sel_o;
    logic [ADDR_W-1:0]              wb_w_addr_o;
    logic [ADDR_W-1:0]              wb_r_addr_o;
    logic                           wb_wr_o;
    logic                           wb_sel_o;
    logic [ADDR_W-1:0]              kb_r_addr_o;
    logic                           ex_sel_o;
    logic [LANE_W-1:0]              ml_sel_o;
    logic                           update_o;
    logic                           ml_clr_o;

    logic [7:0]         stim_mem [MAX_JOBS*STIM_COLS];
    logic [ITER_W-1:0]  up_cnt   [NUM_CTX];
    logic [ITER_W-1:0]  wr_cnt   [NUM_CTX];
    logic [ITER_W-1:0]  job_iter [NUM_CTX];
    logic [NUM_CTX-1:0] job_mask;
    logic [NUM_CTX-1:0] done_prev;

    mac_ctrl_top #(
        .ADDR_W (ADDR_W)
    ) u_mac_ctrl_top (.*);

    always #20 clk_i = ~clk_i;

    task automatic abort_run();
        $display("Done: errors found");
        $fatal(1, "simulation stopped at first error");
    endtask

    `include "tb_checks.svh"

    // per-context monitors, records tagged by ib_r_sel_o
    always @(negedge clk_i) begin
        if (rst_ni) begin
            if (update_o) begin
                up_cnt[ib_r_sel_o] = up_cnt[ib_r_sel_o] + 1'b1;
            end
            if (ob_wr_o) begin
                check_addr("ob_addr_o", ob_addr_o,
                           OB_BASE[ib_r_sel_o] + ADDR_W'(wr_cnt[ib_r_sel_o]));
                check_lane("ml_sel_o", ml_sel_o, wr_cnt[ib_r_sel_o][LANE_W-1:0]);
                wr_cnt[ib_r_sel_o] = wr_cnt[ib_r_sel_o] + 1'b1;
            end
            for (int k = 0; k < NUM_CTX; k++) begin
                if (done_prev[k] && start_i[k] && !done_o[k]) begin
                    $display("done_o[%0d] dropped while its start was still high", k);
                    abort_run();
                end
                // a longer job must not finish ahead of a shorter one
                if (done_o[k] && !done_prev[k]) begin
                    for (int i = 0; i < NUM_CTX; i++) begin
                        if (job_mask[i] && (job_iter[i] < job_iter[k]) && !done_o[i]) begin
                            $display("context %0d finished before context %0d", k, i);
                            abort_run();
                        end
                    end
                end
            end
            done_prev = done_o;
        end
    end

    initial begin
        int                 n_jobs;
        int                 limit;
        logic [NUM_CTX-1:0] mask;
        logic [ADDR_W-1:0]  wb_r_prev;
        logic [ADDR_W-1:0]  kb_r_prev;
        clk_i       = 1'b0;
        rst_ni      = 1'b0;
        start_i     = '0;
        iter_size_i = '0;
        job_mask    = '0;
        done_prev   = '0;
        for (int k = 0; k < NUM_CTX; k++) begin
            job_iter[k] = '0;
            up_cnt[k]   = '0;
            wr_cnt[k]   = '0;
        end
        $readmemh("verif/mac_ctrl_stimulus.txt", stim_mem);
        n_jobs = 0;
        while (n_jobs < MAX_JOBS && !$isunknown(stim_mem[n_jobs*STIM_COLS])) begin
            n_jobs++;
        end
        if (n_jobs == 0) begin
            $display("stimulus file holds no jobs");
            abort_run();
        end

        repeat (3) @(posedge clk_i);
        rst_ni <= 1'b1;

        // nothing may write or finish without a start
        for (int c = 0; c < 16; c++) begin
            @(negedge clk_i);
            check_done("done_o", done_o, '0);
            check_bit("ob_wr_o", ob_wr_o, 1'b0);
            check_bit("wb_wr_o", wb_wr_o, 1'b0);
            check_bit("update_o", update_o, 1'b0);
            check_bit("ml_clr_o", ml_clr_o, 1'b0);
            check_bit("wb_sel_o", wb_sel_o, 1'b0);
            check_bit("ex_sel_o", ex_sel_o, 1'b0);
            // idle records sit at their slot bases once the ring has turned
            if (c >= NUM_CTX) begin
                check_addr("ob_addr_o", ob_addr_o, OB_BASE[ib_r_sel_o]);
                check_addr("ib_r_addr_o", ib_r_addr_o, '0);
                check_addr("wb_w_addr_o", wb_w_addr_o, WB_BASE[ib_r_sel_o]);
                // read addresses lead the tagged record by one clock
                check_addr("wb_r_addr_o", wb_r_prev, WB_BASE[ib_r_sel_o]);
                check_addr("kb_r_addr_o", kb_r_prev, '0);
            end
            wb_r_prev = wb_r_addr_o;
            kb_r_prev = kb_r_addr_o;
        end

        for (int j = 0; j < n_jobs; j++) begin
            @(posedge clk_i);
            mask  = stim_mem[j*STIM_COLS][NUM_CTX-1:0];
            limit = 64;
            for (int k = 0; k < NUM_CTX; k++) begin
                job_iter[k] = stim_mem[j*STIM_COLS+1+k][ITER_W-1:0];
                up_cnt[k]   = '0;
                wr_cnt[k]   = '0;
                iter_size_i[k] <= job_iter[k];
                // 73 + 64n steps, four clocks each
                if (mask[k] && (4 * (73 + 64 * int'(job_iter[k])) + 64 > limit)) begin
                    limit = 4 * (73 + 64 * int'(job_iter[k])) + 64;
                end
            end
            job_mask = mask;
            start_i <= mask;
            wait_for_done(mask, mask, limit);

            repeat (8) begin
                @(negedge clk_i);
                // parked contexts keep the execute path released
                check_bit("ex_sel_o", ex_sel_o, 1'b0);
                check_bit("wb_sel_o", wb_sel_o, 1'b0);
            end
            check_done("done_o", done_o, mask);
            for (int k = 0; k < NUM_CTX; k++) begin
                check_count($sformatf("update_o pulses ctx%0d", k), up_cnt[k],
                            stim_mem[j*STIM_COLS+5+k][ITER_W-1:0]);
                check_count($sformatf("ob_wr_o cycles ctx%0d", k), wr_cnt[k],
                            mask[k] ? ITER_W'(8) : ITER_W'(0));
            end

            @(posedge clk_i);
            start_i <= '0;
            wait_for_done(mask, '0, 32);
            check_done("done_o", done_o, '0);
        end

        $display("Done: no errors");
        $finish;
    end

endmodule

//--- verif/mac_ctrl_stimulus.txt
// columns: start mask, iteration count ctx0..ctx3, expected update pulses ctx0..ctx3
// hex values, one job per line
1 03 05 02 07 03 00 00 00
4 00 00 01 00 00 00 01 00
8 02 01 03 00 00 00 00 00
f 02 00 03 01 02 00 03 01
2 00 04 00 00 00 04 00 00
f 00 03 01 02 00 03 01 02

//--- flist.f
+incdir+verif
common/ctrl_cfg_pkg.sv
common/ctrl_types_pkg.sv
common/ctx_if.sv
sequencer/ctx_sequencer.sv
design/ctx_ring.sv
design/ctx_issue.sv
design/mac_ctrl_top.sv
verif/tb_mac_ctrl.sv
